// ==== hdl/ex_arith_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_arith_unit (
    input  wire ex_pkg::op_e   op_i,
    input  wire ex_pkg::word_t rs_i,
    input  wire ex_pkg::word_t rt_i,
    output ex_pkg::word_t      result_o,
    output logic               overflow_o,
    output logic               trap_o
);
    import ex_pkg::*;

    logic  do_sub;      // subtract rt instead of add
    logic  signed_cmp;
    word_t addend;      // rt or its inverse, carry-in completes the negation
    word_t sum;
    logic  rs_lt_rt;

    // position of the first one from the msb
    function automatic word_t lead_zero_count(input word_t value);
        word_t count;
        begin
            count = word_t'(CLZ_NONE);
            for (int i = 0; i < WORD_W; i++)
            begin
                if (value[i])
                    count = word_t'(WORD_W - 1 - i);    // highest set bit wins
            end
            return count;
        end
    endfunction

    //////////////////////////////////////////////////
    // adder
    //////////////////////////////////////////////////
    assign signed_cmp = (op_i == SLT) || (op_i == TGE) || (op_i == TLT);
    assign do_sub     = (op_i == SUB) || (op_i == SUBU) || signed_cmp;

    assign addend = do_sub ? ~rt_i : rt_i;
    assign sum    = rs_i + addend + word_t'(do_sub);

    // operands of equal sign giving a sum of the other sign
    assign overflow_o = (rs_i[WORD_W-1] == addend[WORD_W-1]) &&
                        (sum[WORD_W-1] != rs_i[WORD_W-1]);

    // signs differ: rs negative means less; else the difference decides
    always_comb
    begin
        if (signed_cmp)
        begin
            if (rs_i[WORD_W-1] != rt_i[WORD_W-1])
                rs_lt_rt = rs_i[WORD_W-1];
            else
                rs_lt_rt = sum[WORD_W-1];
        end
        else
        begin
            rs_lt_rt = (rs_i < rt_i);
        end
    end

    //////////////////////////////////////////////////
    // result and trap
    //////////////////////////////////////////////////
    always_comb
    begin
        case (op_i)
            ADD, ADDU, SUB, SUBU: result_o = sum;
            SLT, SLTU:            result_o = word_t'(rs_lt_rt);
            CLZ:                  result_o = lead_zero_count(rs_i);
            CLO:                  result_o = lead_zero_count(~rs_i);   // ones become zeros
            default:              result_o = '0;
        endcase
    end

    always_comb
    begin
        case (op_i)
            TEQ:       trap_o = (rs_i == rt_i);
            TNE:       trap_o = (rs_i != rt_i);
            TGE, TGEU: trap_o = ~rs_lt_rt;
            TLT, TLTU: trap_o = rs_lt_rt;
            default:   trap_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ex_logic_shift_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_logic_shift_unit (
    input  wire ex_pkg::op_e   op_i,
    input  wire ex_pkg::word_t rs_i,
    input  wire ex_pkg::word_t rt_i,
    output ex_pkg::word_t      result_o
);
    import ex_pkg::*;

    shamt_t shamt;
    word_t  sra_res;

    // variable shifts take the amount from rs
    assign shamt = rs_i[SHAMT_W-1:0];

    // sign bit of rt fills from the top
    assign sra_res = word_t'($signed(rt_i) >>> shamt);

    //////////////////////////////////////////////////
    // logic and shift select
    //////////////////////////////////////////////////
    always_comb
    begin
        case (op_i)
            AND:
                result_o = rs_i & rt_i;     // andi too
            OR:
                result_o = rs_i | rt_i;
            XOR:
                result_o = rs_i ^ rt_i;
            NOR:
                result_o = ~(rs_i | rt_i);
            SLL:
                result_o = rt_i << shamt;   // zero fill
            SRL:
                result_o = rt_i >> shamt;
            SRA:
                result_o = sra_res;
            default:
                result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ex_mul_hilo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mul_hilo (
    input  wire                clk,
    input  wire                rst,
    input  wire                accept_i,
    input  wire ex_pkg::op_e   op_i,
    input  wire ex_pkg::word_t rs_i,
    input  wire ex_pkg::word_t rt_i,
    output ex_pkg::word_t      result_o
);
    import ex_pkg::*;

    logic   is_signed;      // mult, not multu
    logic   neg_product;
    word_t  rs_mag;
    word_t  rt_mag;
    dword_t product_mag;
    dword_t product;

    word_t  hi_q;
    word_t  lo_q;

    //////////////////////////////////////////////////
    // multiplier
    //////////////////////////////////////////////////
    assign is_signed = (op_i == MULT);

    // magnitudes for mult, raw operands for multu
    assign rs_mag = (is_signed && rs_i[WORD_W-1]) ? -rs_i : rs_i;
    assign rt_mag = (is_signed && rt_i[WORD_W-1]) ? -rt_i : rt_i;

    assign product_mag = dword_t'(rs_mag) * dword_t'(rt_mag);

    assign neg_product = is_signed && (rs_i[WORD_W-1] ^ rt_i[WORD_W-1]);
    assign product     = neg_product ? -product_mag : product_mag;

    //////////////////////////////////////////////////
    // hi/lo pair
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else if (accept_i)
        begin
            case (op_i)
                MULT, MULTU:
                begin
                    hi_q <= product[DWORD_W-1:WORD_W];
                    lo_q <= product[WORD_W-1:0];
                end
                MTHI:
                begin
                    hi_q <= rs_i;       // lo untouched
                end
                MTLO:
                begin
                    lo_q <= rs_i;
                end
                default:
                begin
                    hi_q <= hi_q;
                    lo_q <= lo_q;
                end
            endcase
        end
    end

    // moves out of hi/lo
    always_comb
    begin
        case (op_i)
            MFHI:    result_o = hi_q;
            MFLO:    result_o = lo_q;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int WORD_W     = 32;
    localparam int DWORD_W    = 64;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int CLZ_NONE   = 32;     // clz/clo count for no match

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [DWORD_W-1:0]    dword_t;     // product, hi/lo pair
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    //////////////////////////////////////////////////
    // operations seen by the execute stage
    //////////////////////////////////////////////////
    // immediate forms arrive here as the register form
    typedef enum logic [4:0] {
        NOP   = 5'd0,
        AND   = 5'd1,
        OR    = 5'd2,
        XOR   = 5'd3,
        NOR   = 5'd4,
        SLL   = 5'd5,
        SRL   = 5'd6,
        SRA   = 5'd7,
        ADD   = 5'd8,
        ADDU  = 5'd9,
        SUB   = 5'd10,
        SUBU  = 5'd11,
        SLT   = 5'd12,
        SLTU  = 5'd13,
        CLZ   = 5'd14,
        CLO   = 5'd15,
        TEQ   = 5'd16,
        TNE   = 5'd17,
        TGE   = 5'd18,
        TGEU  = 5'd19,
        TLT   = 5'd20,
        TLTU  = 5'd21,
        MULT  = 5'd22,
        MULTU = 5'd23,
        MTHI  = 5'd24,
        MTLO  = 5'd25,
        MFHI  = 5'd26,
        MFLO  = 5'd27,
        LINK  = 5'd28
    } op_e;

    // decode -> execute
    typedef struct packed {
        op_e       op;
        word_t     rs_data;
        word_t     rt_data;
        word_t     link_addr;   // return address for jal/jalr
        reg_addr_t dest;
        logic      gpr_we;
    } ex_req_t;

    // execute -> memory stage
    typedef struct packed {
        word_t     result;
        reg_addr_t dest;
        logic      gpr_we;
        logic      ovf_exc;
        logic      trap_exc;
    } ex_resp_t;

endpackage

`default_nettype wire

// ==== hdl/ex_result_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_result_reg (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  valid_i,
    input  wire                  stall_i,
    input  wire ex_pkg::ex_req_t req_i,
    input  wire ex_pkg::word_t   arith_i,
    input  wire ex_pkg::word_t   logic_shift_i,
    input  wire ex_pkg::word_t   mul_i,
    input  wire                  overflow_i,
    input  wire                  trap_i,
    output logic                 valid_o,
    output ex_pkg::ex_resp_t     resp_o
);
    import ex_pkg::*;

    logic     ovf_kill;     // signed add/sub overflowed
    ex_resp_t resp_d;

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////
    assign ovf_kill = ((req_i.op == ADD) || (req_i.op == SUB)) && overflow_i;

    always_comb
    begin
        resp_d.dest     = req_i.dest;
        resp_d.gpr_we   = req_i.gpr_we & ~ovf_kill;     // no write on exception
        resp_d.ovf_exc  = ovf_kill;
        resp_d.trap_exc = trap_i;
        case (req_i.op)
            AND, OR, XOR, NOR, SLL, SRL, SRA:
                resp_d.result = logic_shift_i;
            ADD, ADDU, SUB, SUBU, SLT, SLTU, CLZ, CLO:
                resp_d.result = arith_i;
            MFHI, MFLO:
                resp_d.result = mul_i;
            LINK:
                resp_d.result = req_i.link_addr;
            default:
                resp_d.result = '0;     // nop, traps, mult, mthi/mtlo
        endcase
    end

    // output register, frozen while downstream stalls
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_o <= 1'b0;
            resp_o  <= '0;
        end
        else if (!stall_i)
        begin
            valid_o <= valid_i;
            if (valid_i)
                resp_o <= resp_d;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  valid_i,
    input  wire ex_pkg::ex_req_t req_i,
    input  wire                  stall_i,
    output logic                 valid_o,
    output ex_pkg::ex_resp_t     resp_o
);
    import ex_pkg::*;

    logic  accept;      // request taken this edge
    word_t arith_res;
    word_t logic_shift_res;
    word_t mul_res;
    logic  overflow;
    logic  trap;

    assign accept = valid_i & ~stall_i;

    //////////////////////////////////////////////////
    // functional units
    //////////////////////////////////////////////////
    ex_arith_unit u_arith (
        .op_i       (req_i.op),
        .rs_i       (req_i.rs_data),
        .rt_i       (req_i.rt_data),
        .result_o   (arith_res),
        .overflow_o (overflow),
        .trap_o     (trap)
    );

    ex_logic_shift_unit u_logic_shift (
        .op_i     (req_i.op),
        .rs_i     (req_i.rs_data),
        .rt_i     (req_i.rt_data),
        .result_o (logic_shift_res)
    );

    ex_mul_hilo u_mul_hilo (
        .clk      (clk),
        .rst      (rst),
        .accept_i (accept),
        .op_i     (req_i.op),
        .rs_i     (req_i.rs_data),
        .rt_i     (req_i.rt_data),
        .result_o (mul_res)
    );

    // select and register toward mem stage
    ex_result_reg u_result (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .stall_i       (stall_i),
        .req_i         (req_i),
        .arith_i       (arith_res),
        .logic_shift_i (logic_shift_res),
        .mul_i         (mul_res),
        .overflow_i    (overflow),
        .trap_i        (trap),
        .valid_o       (valid_o),
        .resp_o        (resp_o)
    );

endmodule

`default_nettype wire

// ==== tests/ex_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   valid_i,      // DUT request side
    input  wire                   stall_i,
    input  wire ex_pkg::ex_resp_t exp_i,        // expected response of the presented row
    input  var  int               row_i,
    input  wire                   out_valid_i,  // DUT response side
    input  wire ex_pkg::ex_resp_t out_resp_i,
    output int                    rows_passed_o,
    output int                    rows_failed_o,
    output int                    errors_o
);
    import ex_pkg::*;

    logic     rst_seen   = 1'b0;
    logic     stall_seen = 1'b0;
    logic     check_now  = 1'b0;   // row taken on the last rising edge
    ex_resp_t pend_exp   = '0;
    int       pend_row   = 0;
    logic     last_valid = 1'b0;
    ex_resp_t last_resp  = '0;

    initial
    begin
        rows_passed_o = 0;
        rows_failed_o = 0;
        errors_o      = 0;
    end

    task automatic compare_field(input string name, input word_t actual,
                                 input word_t expected, inout int bad);
        begin
            if (actual !== expected)
            begin
                $display("Fail %0t ns row %0d %s: expected 0x%08h, actual 0x%08h",
                         $time, pend_row, name, expected, actual);
                bad++;
            end
        end
    endtask

    task automatic check_row();
        int bad;
        begin
            bad = 0;
            if (out_valid_i !== 1'b1)
            begin
                $display("row %0d: valid_o stayed low the cycle after the request was accepted",
                         pend_row);
                bad++;
            end
            else
            begin
                compare_field("result", out_resp_i.result, pend_exp.result, bad);
                compare_field("dest", word_t'(out_resp_i.dest), word_t'(pend_exp.dest), bad);
                compare_field("gpr_we", word_t'(out_resp_i.gpr_we), word_t'(pend_exp.gpr_we), bad);
                compare_field("ovf_exc", word_t'(out_resp_i.ovf_exc),
                              word_t'(pend_exp.ovf_exc), bad);
                compare_field("trap_exc", word_t'(out_resp_i.trap_exc),
                              word_t'(pend_exp.trap_exc), bad);
            end
            if (bad == 0)
            begin
                $display("row %0d: ok", pend_row);
                rows_passed_o++;
            end
            else
            begin
                $display("row %0d: %0d mismatch(es)", pend_row, bad);
                rows_failed_o++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // sample the request side on the rising edge
    //////////////////////////////////////////////////
    always @(posedge clk)
    begin
        rst_seen   = rst;
        stall_seen = stall_i & ~rst;
        check_now  = valid_i & ~stall_i & ~rst;
        if (check_now)
        begin
            pend_exp = exp_i;
            pend_row = row_i;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (rst_seen)
        begin
            if (out_valid_i !== 1'b0 || out_resp_i !== '0)
            begin
                $display("error at %0t ns: outputs not cleared while reset was high", $time);
                errors_o++;
            end
        end
        else if (check_now)
        begin
            check_row();
        end
        else if (stall_seen)
        begin
            if (out_valid_i !== last_valid)
            begin
                $display("Fail %0t ns stall hold valid_o: expected %0b, actual %0b",
                         $time, last_valid, out_valid_i);
                errors_o++;
            end
            if (out_resp_i !== last_resp)
            begin
                $display("Fail %0t ns stall hold resp_o: expected 0x%010h, actual 0x%010h",
                         $time, last_resp, out_resp_i);
                errors_o++;
            end
        end
        else if (out_valid_i !== 1'b0)
        begin
            $display("error at %0t ns: valid_o is high but no request was accepted", $time);
            errors_o++;
        end
        last_valid = out_valid_i;
        last_resp  = out_resp_i;
    end

endmodule

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int NUM_ROWS       = 32;
    localparam int TIMEOUT_CYCLES = 4 * NUM_ROWS + 50;

    typedef struct packed {
        op_e       op;
        word_t     rs;
        word_t     rt;
        word_t     link;
        reg_addr_t dest;
        logic      gpr_we;
        logic      stall;      // hold stall_i for two cycles on this row
        word_t     exp_result;
        logic      exp_we;
        logic      exp_ovf;
        logic      exp_trap;
    } row_t;

    logic     clk   = 1'b0;
    logic     rst   = 1'b1;
    logic     valid = 1'b0;
    logic     stall = 1'b0;
    ex_req_t  req   = '0;
    logic     out_valid;
    ex_resp_t out_resp;

    ex_resp_t exp_resp = '0;
    int       row_idx  = 0;
    int       rows_passed;
    int       rows_failed;
    int       errors;

    row_t     rows [NUM_ROWS];
    int       row_count   = 0;
    int       cycle_count = 0;

    always #4 clk = ~clk;

    ex_stage u_dut (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid),
        .req_i   (req),
        .stall_i (stall),
        .valid_o (out_valid),
        .resp_o  (out_resp)
    );

    ex_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid),
        .stall_i       (stall),
        .exp_i         (exp_resp),
        .row_i         (row_idx),
        .out_valid_i   (out_valid),
        .out_resp_i    (out_resp),
        .rows_passed_o (rows_passed),
        .rows_failed_o (rows_failed),
        .errors_o      (errors)
    );

    // req_flags is {gpr_we, stall}, exp_flags is {gpr_we, ovf_exc, trap_exc}
    task automatic add_row(input op_e op, input word_t rs, input word_t rt, input word_t link,
                           input reg_addr_t dest, input logic [1:0] req_flags,
                           input word_t exp_result, input logic [2:0] exp_flags);
        begin
            rows[row_count] = '{op, rs, rt, link, dest, req_flags[1], req_flags[0],
                                exp_result, exp_flags[2], exp_flags[1], exp_flags[0]};
            row_count++;
        end
    endtask

    // present one row on the falling edge, stall rows keep it presented
    task automatic apply_row(input int idx);
        row_t r;
        begin
            r = rows[idx];
            @(negedge clk);
            valid             = 1'b1;
            req.op            = r.op;
            req.rs_data       = r.rs;
            req.rt_data       = r.rt;
            req.link_addr     = r.link;
            req.dest          = r.dest;
            req.gpr_we        = r.gpr_we;
            exp_resp.result   = r.exp_result;
            exp_resp.dest     = r.dest;
            exp_resp.gpr_we   = r.exp_we;
            exp_resp.ovf_exc  = r.exp_ovf;
            exp_resp.trap_exc = r.exp_trap;
            row_idx           = idx;
            if (r.stall)
            begin
                stall = 1'b1;
                repeat (2) @(negedge clk);
                stall = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus and expected values
    //////////////////////////////////////////////////
    initial
    begin
        add_row(AND,   'hF0F01234, 'h0FF0FF00, '0, 5'd1,  2'b10, 'h00F01200, 3'b100);
        add_row(OR,    'hF0F01234, 'h0FF0FF00, '0, 5'd2,  2'b10, 'hFFF0FF34, 3'b100);
        add_row(XOR,   'hF0F01234, 'h0FF0FF00, '0, 5'd3,  2'b10, 'hFF00ED34, 3'b100);
        add_row(NOR,   'hF0F01234, 'h0FF0FF00, '0, 5'd4,  2'b10, 'h000F00CB, 3'b100);
        add_row(SLL,   'h00000004, 'h80000001, '0, 5'd5,  2'b10, 'h00000010, 3'b100);
        add_row(SRL,   'h00000004, 'h80000010, '0, 5'd6,  2'b10, 'h08000001, 3'b100);
        add_row(SRA,   'h00000008, 'h80001200, '0, 5'd7,  2'b10, 'hFF800012, 3'b100);
        add_row(ADD,   'h7FFFFFFF, 'h00000001, '0, 5'd8,  2'b10, 'h80000000, 3'b010);
        add_row(ADDU,  'h7FFFFFFF, 'h00000001, '0, 5'd9,  2'b10, 'h80000000, 3'b100);
        add_row(SUB,   'd100,      'd58,       '0, 5'd10, 2'b10, 'h0000002A, 3'b100);
        add_row(SUBU,  'h00000000, 'h00000001, '0, 5'd11, 2'b11, 'hFFFFFFFF, 3'b100);
        add_row(SLT,   'hFFFFFFFF, 'h00000001, '0, 5'd12, 2'b10, 'h00000001, 3'b100);
        add_row(SLTU,  'hFFFFFFFF, 'h00000001, '0, 5'd13, 2'b10, 'h00000000, 3'b100);
        add_row(CLZ,   'h00010000, '0,         '0, 5'd14, 2'b10, 'd15,       3'b100);
        add_row(CLZ,   'h00000000, '0,         '0, 5'd15, 2'b10, 'd32,       3'b100);
        add_row(CLO,   'hF0000000, '0,         '0, 5'd16, 2'b10, 'd4,        3'b100);
        add_row(TEQ,   'h00000005, 'h00000005, '0, 5'd0,  2'b00, '0,         3'b001);
        add_row(TLTU,  'h00000001, 'h00000002, '0, 5'd0,  2'b00, '0,         3'b001);
        add_row(TGE,   'hFFFFFFFF, 'h00000000, '0, 5'd0,  2'b00, '0,         3'b000);
        add_row(MULT,  'hFFFFFFFD, 'h00000005, '0, 5'd0,  2'b00, '0,         3'b000);
        add_row(MFHI,  '0,         '0,         '0, 5'd17, 2'b10, 'hFFFFFFFF, 3'b100);
        add_row(MFLO,  '0,         '0,         '0, 5'd18, 2'b10, 'hFFFFFFF1, 3'b100);
        add_row(MULTU, 'h00010000, 'h00030000, '0, 5'd0,  2'b01, '0,         3'b000);
        add_row(MFHI,  '0,         '0,         '0, 5'd19, 2'b10, 'h00000003, 3'b100);
        add_row(MFLO,  '0,         '0,         '0, 5'd20, 2'b10, 'h00000000, 3'b100);
        add_row(MTHI,  'hDEADBEEF, '0,         '0, 5'd0,  2'b00, '0,         3'b000);
        add_row(MTLO,  'h12345678, '0,         '0, 5'd0,  2'b00, '0,         3'b000);
        add_row(MFHI,  '0,         '0,         '0, 5'd21, 2'b10, 'hDEADBEEF, 3'b100);
        add_row(MFLO,  '0,         '0,         '0, 5'd22, 2'b10, 'h12345678, 3'b100);
        add_row(LINK,  '0, '0, 'h00400108,         5'd31, 2'b10, 'h00400108, 3'b100);
        add_row(NOP,   '0,         '0,         '0, 5'd0,  2'b00, '0,         3'b000);
        add_row(TLT,   'hFFFFFFFE, 'h00000003, '0, 5'd0,  2'b00, '0,         3'b001);

        // reset for four rising edges, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(i);

        @(negedge clk);
        valid = 1'b0;
        req   = '0;

        wait (rows_passed + rows_failed == NUM_ROWS);
        repeat (2) @(negedge clk);      // catch a late extra valid_o

        $display("summary: %0d rows passed, %0d rows failed, %0d other errors",
                 rows_passed, rows_failed, errors);
        if (rows_failed == 0 && errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // run limit
    //////////////////////////////////////////////////
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, only %0d of %0d rows were checked",
                     cycle_count, rows_passed + rows_failed, NUM_ROWS);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/ex_pkg.sv
hdl/ex_arith_unit.sv
hdl/ex_logic_shift_unit.sv
hdl/ex_mul_hilo.sv
hdl/ex_result_reg.sv
hdl/ex_stage.sv
tests/ex_checker.sv
tests/tb_ex_stage.sv
